// File: design/cnn_test_macros.svh
`ifndef CNN_TEST_MACROS_SVH
`define CNN_TEST_MACROS_SVH

//////////////////////////////
// serial config link widths
//////////////////////////////
// chip register address
`define CFG_ADDR_W 7
// chip register value
`define CFG_DATA_W 16
// outgoing frame, data above address
`define CFG_FRAME_W (`CFG_DATA_W + `CFG_ADDR_W)

//////////////////////////////
// apb host port
//////////////////////////////
`define APB_ADDR_W 8
`define APB_DATA_W 32

// byte offsets of the host registers
`define REG_CTRL     8'h00
`define REG_CFG_ADDR 8'h04
`define REG_CFG_DATA 8'h08
`define REG_CMD      8'h0C
`define REG_STATUS   8'h10
`define REG_RDATA    8'h14

// done flag stays up this many cycles past the first one
`define DONE_HOLD 100

`endif

// File: design/cnn_test_pkg.sv
`include "cnn_test_macros.svh"

package cnn_test_pkg;

    //////////////////////////////
    // plain vector types
    //////////////////////////////
    typedef logic [`CFG_ADDR_W-1:0]  cfg_addr_t;
    typedef logic [`CFG_DATA_W-1:0]  cfg_data_t;
    typedef logic [`CFG_FRAME_W-1:0] cfg_frame_t;
    typedef logic [`APB_ADDR_W-1:0]  apb_addr_t;
    typedef logic [`APB_DATA_W-1:0]  apb_data_t;

    //////////////////////////////
    // host regs <-> config link
    //////////////////////////////
    // one-cycle command, addr and data valid with it
    typedef struct packed {
        logic      wr;
        logic      rd;
        cfg_addr_t addr;
        cfg_data_t data;
    } cfg_req_t;

    // link status and last readback value
    typedef struct packed {
        logic      busy;
        logic      rdata_valid;
        cfg_data_t rdata;
    } cfg_rsp_t;

    // state machines
    typedef enum logic [1:0] {IDLE, SHIFT, STROBE, COLLECT} link_state_t;
    typedef enum logic {WAIT_DONE, HOLD} stretch_state_t;

endpackage

// File: design/cnn_test_top.sv
`timescale 1ns/1ps

module cnn_test_top
    import cnn_test_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    // apb host port
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  apb_addr_t  paddr,
    input  apb_data_t  pwdata,
    output apb_data_t  prdata,
    output logic       pready,
    output logic       pslverr,
    // serial config pins
    output logic       spi_din,
    output logic       cfg_update,
    output logic       cfg_capture,
    input  logic       spi_out,
    // cnn done
    input  logic       done,
    output logic       done_flag,
    // chip control
    output logic       init,
    output logic       en_evt2frame,
    output logic [7:0] led
);

    // between host regs and link
    cfg_req_t cfg_req;
    cfg_rsp_t cfg_rsp;

    //////////////////////////////
    // host registers
    //////////////////////////////
    host_regs u_host_regs (
        .clk          (clk),
        .reset        (reset),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .cfg_req      (cfg_req),
        .cfg_rsp      (cfg_rsp),
        .done_flag    (done_flag),
        .init         (init),
        .en_evt2frame (en_evt2frame),
        .led          (led)
    );

    //////////////////////////////
    // serial link
    //////////////////////////////
    spi_config_link u_spi_config_link (
        .clk         (clk),
        .reset       (reset),
        .cfg_req     (cfg_req),
        .cfg_rsp     (cfg_rsp),
        .spi_din     (spi_din),
        .cfg_update  (cfg_update),
        .cfg_capture (cfg_capture),
        .spi_out     (spi_out)
    );

    // done widening, flag also feeds the status bit
    done_stretcher u_done_stretcher (
        .clk       (clk),
        .reset     (reset),
        .done      (done),
        .done_flag (done_flag)
    );

endmodule

// File: design/done_stretcher.sv
`timescale 1ns/1ps
`include "cnn_test_macros.svh"

module done_stretcher
    import cnn_test_pkg::*;
(
    input  logic clk,
    input  logic reset,
    // short pulse from the chip
    input  logic done,
    // widened flag, DONE_HOLD+1 cycles
    output logic done_flag
);

    localparam int HOLD_W = $clog2(`DONE_HOLD + 1);

    stretch_state_t    state;
    logic [HOLD_W-1:0] hold_cnt;

    //////////////////////////////
    // stretch fsm
    //////////////////////////////
    // counter runs 0..DONE_HOLD inside HOLD
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= WAIT_DONE;
            hold_cnt <= '0;
        end else begin
            case (state)
                WAIT_DONE: begin
                    hold_cnt <= '0;
                    if (done) begin
                        state <= HOLD;
                    end
                end
                HOLD: begin
                    // done ignored here, pulse already caught
                    if (hold_cnt == HOLD_W'(`DONE_HOLD)) begin
                        hold_cnt <= '0;
                        state    <= WAIT_DONE;
                    end else begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= WAIT_DONE;
                end
            endcase
        end
    end

    // flag is the hold state itself
    assign done_flag = (state == HOLD);

endmodule

// File: design/host_regs.sv
`timescale 1ns/1ps
`include "cnn_test_macros.svh"

module host_regs
    import cnn_test_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    // apb slave
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  apb_addr_t  paddr,
    input  apb_data_t  pwdata,
    output apb_data_t  prdata,
    output logic       pready,
    output logic       pslverr,
    // serial config link
    output cfg_req_t   cfg_req,
    input  cfg_rsp_t   cfg_rsp,
    // stretched done from the chip
    input  logic       done_flag,
    // chip control pins
    output logic       init,
    output logic       en_evt2frame,
    output logic [7:0] led
);

    // offset decode
    logic sel_ctrl;
    logic sel_addr;
    logic sel_data;
    logic sel_cmd;
    logic sel_status;
    logic sel_rdata;
    logic addr_hit;
    // transfer qualifiers
    logic cmd_stall;
    logic xfer;
    logic wr_xfer;
    logic rd_xfer;
    // held registers
    cfg_addr_t cfg_addr_q;
    cfg_data_t cfg_data_q;
    logic      req_wr;
    logic      req_rd;
    logic      done_q;
    logic      done_seen;

    //////////////////////////////
    // apb decode
    //////////////////////////////
    assign sel_ctrl   = (paddr == `REG_CTRL);
    assign sel_addr   = (paddr == `REG_CFG_ADDR);
    assign sel_data   = (paddr == `REG_CFG_DATA);
    assign sel_cmd    = (paddr == `REG_CMD);
    assign sel_status = (paddr == `REG_STATUS);
    assign sel_rdata  = (paddr == `REG_RDATA);
    assign addr_hit   = sel_ctrl | sel_addr | sel_data | sel_cmd | sel_status | sel_rdata;

    // command write waits for the link to go idle
    assign cmd_stall = psel & pwrite & sel_cmd & cfg_rsp.busy;
    assign pready    = ~cmd_stall;
    assign pslverr   = psel & penable & ~addr_hit;

    // transfer completes on this edge
    assign xfer    = psel & penable & pready;
    assign wr_xfer = xfer & pwrite;
    assign rd_xfer = xfer & ~pwrite;

    //////////////////////////////
    // writable registers
    //////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            init         <= 1'b0;
            en_evt2frame <= 1'b0;
            led          <= '0;
        end else if (wr_xfer && sel_ctrl) begin
            init         <= pwdata[0];
            en_evt2frame <= pwdata[1];
            led          <= pwdata[15:8];
        end
    end

    // target chip register and value for the next command
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg_addr_q <= '0;
            cfg_data_q <= '0;
        end else begin
            if (wr_xfer && sel_addr) begin
                cfg_addr_q <= pwdata[`CFG_ADDR_W-1:0];
            end
            if (wr_xfer && sel_data) begin
                cfg_data_q <= pwdata[`CFG_DATA_W-1:0];
            end
        end
    end

    // command strobes one cycle after the access
    // write has priority and a read is dropped when both are set
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            req_wr <= 1'b0;
            req_rd <= 1'b0;
        end else begin
            req_wr <= wr_xfer & sel_cmd & pwdata[0];
            req_rd <= wr_xfer & sel_cmd & pwdata[1] & ~pwdata[0];
        end
    end

    assign cfg_req.wr   = req_wr;
    assign cfg_req.rd   = req_rd;
    assign cfg_req.addr = cfg_addr_q;
    assign cfg_req.data = cfg_data_q;

    //////////////////////////////
    // sticky done status
    //////////////////////////////
    // new rising edge beats a clearing status read
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done_q    <= 1'b0;
            done_seen <= 1'b0;
        end else begin
            done_q <= done_flag;
            if (done_flag && !done_q) begin
                done_seen <= 1'b1;
            end else if (rd_xfer && sel_status) begin
                done_seen <= 1'b0;
            end
        end
    end

    // read mux
    always_comb begin
        case (paddr)
            `REG_CTRL:     prdata = {16'b0, led, 6'b0, en_evt2frame, init};
            `REG_CFG_ADDR: prdata = apb_data_t'(cfg_addr_q);
            `REG_CFG_DATA: prdata = apb_data_t'(cfg_data_q);
            `REG_STATUS:   prdata = {29'b0, done_seen, cfg_rsp.rdata_valid, cfg_rsp.busy};
            `REG_RDATA:    prdata = apb_data_t'(cfg_rsp.rdata);
            // cmd is write-only
            default:       prdata = '0;
        endcase
    end

    // back-to-back commands are at least two apb cycles apart
    a_req_one_cycle: assert property (@(posedge clk) disable iff (reset)
        (cfg_req.wr || cfg_req.rd) |=> !(cfg_req.wr || cfg_req.rd))
        else $error("config request strobe held for more than one cycle");

endmodule

// File: design/spi_config_link.sv
`timescale 1ns/1ps
`include "cnn_test_macros.svh"

module spi_config_link
    import cnn_test_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    // from host regs
    input  cfg_req_t cfg_req,
    output cfg_rsp_t cfg_rsp,
    // chip serial pins
    output logic     spi_din,
    output logic     cfg_update,
    output logic     cfg_capture,
    input  logic     spi_out
);

    // enough for the longer of frame and readback
    localparam int CNT_W = $clog2(`CFG_FRAME_W);

    link_state_t      state;
    logic [CNT_W-1:0] bit_cnt;
    logic             is_read;
    logic             rdata_valid_q;
    cfg_data_t        rdata_q;
    cfg_frame_t       frame_q;
    cfg_data_t        rx_q;
    logic             req_any;
    logic             last_tx;
    logic             last_rx;

    assign req_any = cfg_req.wr | cfg_req.rd;
    assign last_tx = (bit_cnt == CNT_W'(`CFG_FRAME_W - 1));
    assign last_rx = (bit_cnt == CNT_W'(`CFG_DATA_W - 1));

    //////////////////////////////
    // link fsm
    //////////////////////////////
    // IDLE    wait for a request
    // SHIFT   23 frame bits lsb first
    // STROBE  one cycle of update or capture
    // COLLECT 16 readback bits lsb first
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state         <= IDLE;
            bit_cnt       <= '0;
            is_read       <= 1'b0;
            rdata_valid_q <= 1'b0;
            rdata_q       <= '0;
        end else begin
            case (state)
                IDLE: begin
                    bit_cnt <= '0;
                    if (req_any) begin
                        // write wins if both are seen
                        is_read       <= ~cfg_req.wr;
                        rdata_valid_q <= 1'b0;
                        state         <= SHIFT;
                    end
                end
                SHIFT: begin
                    if (last_tx) begin
                        bit_cnt <= '0;
                        state   <= STROBE;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                STROBE: begin
                    state <= is_read ? COLLECT : IDLE;
                end
                COLLECT: begin
                    if (last_rx) begin
                        // last bit goes straight into the held value
                        rdata_q       <= {spi_out, rx_q[`CFG_DATA_W-1:1]};
                        rdata_valid_q <= 1'b1;
                        bit_cnt       <= '0;
                        state         <= IDLE;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    //////////////////////////////
    // shift registers
    //////////////////////////////
    // tx frame loads on request and shifts right each SHIFT cycle
    // rx fills from the top so the first bit lands at bit 0
    always_ff @(posedge clk) begin
        if (state == IDLE && req_any) begin
            if (cfg_req.wr) begin
                frame_q <= {cfg_req.data, cfg_req.addr};
            end else begin
                frame_q <= cfg_frame_t'(cfg_req.addr);
            end
        end else if (state == SHIFT) begin
            frame_q <= frame_q >> 1;
        end
        if (state == COLLECT) begin
            rx_q <= {spi_out, rx_q[`CFG_DATA_W-1:1]};
        end
    end

    // chip pins
    assign spi_din     = (state == SHIFT) & frame_q[0];
    assign cfg_update  = (state == STROBE) & ~is_read;
    assign cfg_capture = (state == STROBE) & is_read;

    // status back to the host
    assign cfg_rsp.busy        = (state != IDLE);
    assign cfg_rsp.rdata_valid = rdata_valid_q;
    assign cfg_rsp.rdata       = rdata_q;

    // host regs must hold commands off while the link runs
    a_no_req_busy: assert property (@(posedge clk) disable iff (reset)
        cfg_rsp.busy |-> !req_any)
        else $error("config request arrived while link busy");

    // readback ends 17 cycles after capture with valid data and an idle link
    a_readback_len: assert property (@(posedge clk) disable iff (reset)
        cfg_capture |-> ##(`CFG_DATA_W + 1) (cfg_rsp.rdata_valid && !cfg_rsp.busy))
        else $error("readback did not end with valid data after 16 sample cycles");

endmodule

// File: sources.f
+incdir+design
design/cnn_test_pkg.sv
design/host_regs.sv
design/spi_config_link.sv
design/done_stretcher.sv
design/cnn_test_top.sv
verification/clock_gen.sv
verification/tb_cnn_test.sv

// File: verification/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
    parameter real PERIOD     = 4.0,
    parameter int  RST_CYCLES = 3
) (
    output logic clk,
    output logic reset
);

    // free-running testbench clock
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    // held over the first rising edges, dropped on a falling one
    initial begin
        reset = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// File: verification/cnn_test_stimulus.txt
# columns: operation, then its operands in hex (DONE length in decimal cycles)
# CTRL value | WRITE addr data | READ addr chip_value expected | DONE length
# BUSY addr1 data1 addr2 data2 | BAD offset
CTRL 00000001
CTRL 0000A502
CTRL 0000FF03
CTRL 00000000
WRITE 05 1234
WRITE 7F FFFF
WRITE 00 0001
WRITE 2A 8000
WRITE 55 A5A5
READ 05 BEEF BEEF
READ 7F 0001 0001
READ 11 8000 8000
READ 40 5A5A 5A5A
READ 00 FFFF FFFF
# write after read clears rdata_valid
WRITE 33 7777
BUSY 12 CAFE 34 F00D
BUSY 7E 0F0F 01 1111
READ 33 1357 1357
DONE 1
DONE 2
DONE 3
DONE 4
DONE 5
BAD 18
BAD 01
BAD FC
CTRL 0000C301

// File: verification/tb_cnn_test.sv
`timescale 1ns/1ps
`include "cnn_test_macros.svh"

module tb_cnn_test
    import cnn_test_pkg::*;
;

    // limit for every wait, in cycles or status polls
    localparam int TIMEOUT = 400;

    logic       clk;
    logic       reset;
    logic       psel;
    logic       penable;
    logic       pwrite;
    apb_addr_t  paddr;
    apb_data_t  pwdata;
    apb_data_t  prdata;
    logic       pready;
    logic       pslverr;
    logic       spi_din;
    logic       cfg_update;
    logic       cfg_capture;
    logic       spi_out = 1'b0;
    logic       done;
    logic       done_flag;
    logic       init;
    logic       en_evt2frame;
    logic [7:0] led;

    // run bookkeeping
    int tests = 0;
    int checks = 0;
    int errors = 0;
    int test_errors = 0;
    int fd;
    // result of the last apb transfer
    apb_data_t last_rdata;
    logic      last_err;
    int        last_waits;

    // chip model state
    cfg_frame_t shift_hist = '0;
    cfg_frame_t frames[$];
    int         update_count = 0;
    int         capture_count = 0;
    int         rx_idx = `CFG_DATA_W;
    cfg_data_t  chip_value = '0;

    clock_gen u_clock_gen (.clk(clk), .reset(reset));
    cnn_test_top DUT (.*);

    //////////////////////////////
    // chip model
    //////////////////////////////
    // falling edge, pins settled mid-cycle
    always @(negedge clk) begin
        // a strobe closes the frame shifted in so far
        if (cfg_update || cfg_capture) begin
            frames.push_back(shift_hist);
        end else begin
            shift_hist = {spi_din, shift_hist[`CFG_FRAME_W-1:1]};
        end
        if (cfg_update) begin
            update_count++;
        end
        // readback lsb first, one bit per cycle after capture
        if (rx_idx < `CFG_DATA_W) begin
            spi_out = chip_value[rx_idx];
            rx_idx++;
        end else begin
            spi_out = 1'b0;
        end
        if (cfg_capture) begin
            capture_count++;
            rx_idx = 0;
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////
    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERROR time=%0t %0s got=0x%0h expected=0x%0h", $time, name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic expect_true(input logic cond, input string msg);
        checks++;
        assert (cond === 1'b1) else begin
            $display("time %0t: %0s", $time, msg);
            errors++;
            test_errors++;
        end
    endtask

    task automatic close_test(input string label);
        tests++;
        $display("test %0d %0s: %0d errors", tests, label, test_errors);
        test_errors = 0;
    endtask

    //////////////////////////////
    // apb master
    //////////////////////////////
    // setup phase, then access phase until pready
    task automatic apb_xfer(input logic write, input apb_addr_t addr, input apb_data_t wdata);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        // look just past the falling edge, value holds to the rising one
        #1;
        last_waits = 0;
        while (!pready && last_waits < TIMEOUT) begin
            @(negedge clk);
            #1;
            last_waits++;
        end
        expect_true(pready, "apb transfer never completed, pready stuck low");
        last_rdata = prdata;
        last_err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // status polls until busy drops
    task automatic poll_idle();
        int polls;
        polls = 0;
        apb_xfer(1'b0, `REG_STATUS, '0);
        while (last_rdata[0] && polls < TIMEOUT) begin
            apb_xfer(1'b0, `REG_STATUS, '0);
            polls++;
        end
        expect_true(!last_rdata[0], "serial link stayed busy past the timeout");
    endtask

    // one serial command and its frame on the pins
    task automatic send_command(input apb_data_t cmd, input cfg_frame_t exp_frame);
        frames.delete();
        update_count  = 0;
        capture_count = 0;
        apb_xfer(1'b1, `REG_CMD, cmd);
        poll_idle();
        compare_value("status.rdata_valid", last_rdata[1], cmd[1] & ~cmd[0]);
        compare_value("cfg_update pulses", update_count, cmd[0]);
        compare_value("cfg_capture pulses", capture_count, cmd[1] & ~cmd[0]);
        compare_value("frames seen", frames.size(), 1);
        if (frames.size() > 0) begin
            compare_value("spi_din frame", frames[0], exp_frame);
        end
    endtask

    //////////////////////////////
    // stimulus operations
    //////////////////////////////
    task automatic run_operation(input logic [63:0] op);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        int          code;
        int          n;
        int          high;
        int          rise_at;
        string       label;
        code = 1;
        if (op == "CTRL") begin
            code  = $fscanf(fd, "%h", a);
            label = "ctrl";
            apb_xfer(1'b1, `REG_CTRL, a);
            compare_value("init", init, a[0]);
            compare_value("en_evt2frame", en_evt2frame, a[1]);
            compare_value("led", led, a[15:8]);
            apb_xfer(1'b0, `REG_CTRL, '0);
            compare_value("prdata ctrl", last_rdata, {16'b0, a[15:8], 6'b0, a[1:0]});
        end else if (op == "WRITE") begin
            code  = $fscanf(fd, "%h %h", a, b);
            label = "serial write";
            apb_xfer(1'b1, `REG_CFG_ADDR, a);
            apb_xfer(1'b1, `REG_CFG_DATA, b);
            send_command(32'h1, {b[`CFG_DATA_W-1:0], a[`CFG_ADDR_W-1:0]});
        end else if (op == "READ") begin
            code  = $fscanf(fd, "%h %h %h", a, b, c);
            label = "serial read";
            chip_value = b[`CFG_DATA_W-1:0];
            apb_xfer(1'b1, `REG_CFG_ADDR, a);
            // address frame, data half all zero
            send_command(32'h2, cfg_frame_t'(a[`CFG_ADDR_W-1:0]));
            apb_xfer(1'b0, `REG_RDATA, '0);
            compare_value("prdata rdata", last_rdata, c);
        end else if (op == "BUSY") begin
            code  = $fscanf(fd, "%h %h %h %h", a, b, c, d);
            label = "command while busy";
            apb_xfer(1'b1, `REG_CFG_ADDR, a);
            apb_xfer(1'b1, `REG_CFG_DATA, b);
            frames.delete();
            update_count = 0;
            apb_xfer(1'b1, `REG_CMD, 32'h1);
            // reload while the first frame is still shifting
            apb_xfer(1'b1, `REG_CFG_ADDR, c);
            apb_xfer(1'b1, `REG_CFG_DATA, d);
            apb_xfer(1'b1, `REG_CMD, 32'h1);
            expect_true(last_waits > 0, "command write on a busy link was not held off");
            poll_idle();
            compare_value("cfg_update pulses", update_count, 2);
            compare_value("frames seen", frames.size(), 2);
            if (frames.size() == 2) begin
                compare_value("first frame", frames[0], {b[`CFG_DATA_W-1:0], a[`CFG_ADDR_W-1:0]});
                compare_value("second frame", frames[1], {d[`CFG_DATA_W-1:0], c[`CFG_ADDR_W-1:0]});
            end
        end else if (op == "DONE") begin
            code  = $fscanf(fd, "%d", a);
            label = "done stretch";
            @(negedge clk);
            done    = 1'b1;
            n       = 0;
            high    = 0;
            rise_at = 0;
            // until the flag has risen and fallen again
            while (!(high > 0 && !done_flag) && n < TIMEOUT) begin
                @(negedge clk);
                n++;
                if (n == a) begin
                    done = 1'b0;
                end
                if (done_flag) begin
                    rise_at = (high == 0) ? n : rise_at;
                    high++;
                end
            end
            expect_true(high > 0 && !done_flag, "done_flag did not finish its stretch in time");
            compare_value("done_flag rise cycle", rise_at, 1);
            compare_value("done_flag high cycles", high, `DONE_HOLD + 1);
            // sticky bit, cleared by the read that shows it
            apb_xfer(1'b0, `REG_STATUS, '0);
            compare_value("status.done_seen first read", last_rdata[2], 1);
            apb_xfer(1'b0, `REG_STATUS, '0);
            compare_value("status.done_seen second read", last_rdata[2], 0);
        end else if (op == "BAD") begin
            code  = $fscanf(fd, "%h", a);
            label = "unmapped offset";
            apb_xfer(1'b0, a[7:0], '0);
            compare_value("pslverr on read", last_err, 1);
            apb_xfer(1'b1, a[7:0], 32'hffff_ffff);
            compare_value("pslverr on write", last_err, 1);
        end else begin
            label = "unknown";
            expect_true(1'b0, "unknown operation in the stimulus file");
        end
        expect_true(code > 0, "stimulus line is missing its operands");
        close_test(label);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin : main
        logic [63:0]  op;
        logic [959:0] line_buf;
        int           code;
        int           n;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        done    = 1'b0;
        n = $urandom(32'h2484);
        // wait out reset
        n = 0;
        while (reset !== 1'b0 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        expect_true(reset === 1'b0, "reset was never released");
        compare_value("init", init, 0);
        compare_value("en_evt2frame", en_evt2frame, 0);
        compare_value("led", led, 0);
        compare_value("done_flag", done_flag, 0);
        compare_value("cfg_update", cfg_update, 0);
        compare_value("cfg_capture", cfg_capture, 0);
        apb_xfer(1'b0, `REG_STATUS, '0);
        compare_value("prdata status", last_rdata, 0);
        compare_value("pslverr", last_err, 0);
        close_test("reset");
        fd = $fopen("verification/cnn_test_stimulus.txt", "r");
        if (fd == 0) begin
            expect_true(1'b0, "cannot open verification/cnn_test_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                op   = '0;
                code = $fscanf(fd, "%s", op);
                if (code == 1 && op == "#") begin
                    // drop the rest of a comment line
                    code = $fgets(line_buf, fd);
                end else if (code == 1) begin
                    // random idle gap
                    repeat ($urandom % 4) @(negedge clk);
                    run_operation(op);
                end
            end
            $fclose(fd);
        end
        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
